// ==== include/ebus_settings.svh ====
`ifndef EBUS_SETTINGS_SVH
`define EBUS_SETTINGS_SVH

// I/O port map, low address byte
`define EBUS_IO_BANK0          8'hF0
`define EBUS_IO_BANK1          8'hF1
`define EBUS_IO_BANK2          8'hF2
`define EBUS_IO_BANK3          8'hF3
`define EBUS_IO_CASSETTE       8'hFC
`define EBUS_IO_VSYNC_CPM      8'hFD   // R: vsync, W: CP/M remap
`define EBUS_IO_PRINTER        8'hFE
`define EBUS_IO_KEYB_SCRAMBLE  8'hFF   // R: keyboard, W: scramble

// Bank registers after reset, {ro, overlay, page}
`define EBUS_BANK0_RESET       8'hDF   // RO + overlay, page 31
`define EBUS_BANK1_RESET       8'h21   // Page 33
`define EBUS_BANK2_RESET       8'h22   // Page 34
`define EBUS_BANK3_RESET       8'h13   // Page 19

`define EBUS_BOOT_PAGE         6'd31

// Physical page ranges
`define EBUS_ROM_PAGE_LAST     6'd15   // ROM from page 0
`define EBUS_CART_PAGE_FIRST   6'd16
`define EBUS_CART_PAGE_LAST    6'd19
`define EBUS_RAM_PAGE_FIRST    6'd32   // RAM up to page 63

// Overlay windows, a[13:11] inside the 16 KB window
`define EBUS_VRAM_WIN          3'b110  // $3000-$37FF
`define EBUS_SYSRAM_WIN        3'b111  // $3800-$3FFF
`define EBUS_VRAM_BYTES        2048

`endif

// ==== rtl/ebus_pkg.sv ====
package ebus_pkg;

    //////////////////////////////
    // Paging types
    //////////////////////////////

    // Physical 16 KB page, 64 of them
    typedef logic [5:0] page_t;

    // Bank register at ports F0-F3, one per CPU window
    typedef struct packed {
        logic  ro;       // Writes do not reach the chip
        logic  overlay;  // VRAM and sysram mapped at $3000-$3FFF
        page_t page;     // Bits 5:0
    } bank_reg_t;

endpackage

// ==== rtl/strobe_sync.sv ====
`timescale 1ns/1ps

module strobe_sync (
    input  logic       sysclk,
    input  logic       reset,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic [7:0] d_in,
    output logic       bus_read,
    output logic       bus_write,
    output logic [7:0] wrdata
);

    logic [2:0] rd_n_sr;  // [0] is the sync stage
    logic [2:0] wr_n_sr;

    //////////////////////////////
    // Strobe sampling
    //////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_n_sr <= 3'b111;  // Bus idle
            wr_n_sr <= 3'b111;
        end else begin
            rd_n_sr <= {rd_n_sr[1:0], rd_n};
            wr_n_sr <= {wr_n_sr[1:0], wr_n};
        end
    end

    // Falling edge seen between the two upper stages
    assign bus_read  = rd_n_sr[2:1] == 2'b10;
    assign bus_write = wr_n_sr[2:1] == 2'b10;

    // Write data follows d_in while wr_n is low
    always_ff @(posedge sysclk) begin
        if (!wr_n) begin
            wrdata <= d_in;
        end
    end

    // The CPU never asserts both strobes, and the pulses sit on separate edges
    a_no_rd_wr_overlap: assert property (
        @(posedge sysclk) disable iff (reset)
        !(bus_read && bus_write)
    ) else $error("strobe_sync: read and write pulse in the same cycle");

endmodule

// ==== rtl/bank_map.sv ====
`timescale 1ns/1ps
`include "ebus_settings.svh"

module bank_map import ebus_pkg::*; (
    input  logic [15:0] a,
    input  logic        mreq_n,
    input  logic        wr_n,
    input  bank_reg_t   bank0,
    input  bank_reg_t   bank1,
    input  bank_reg_t   bank2,
    input  bank_reg_t   bank3,
    input  logic        sel_io_any,
    output logic        sel_vram,
    output logic        sel_sysram,
    output logic        sel_bootrom,
    output logic [4:0]  ba,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic        cart_ce_n
);

    bank_reg_t bank;       // Register of the current window
    logic      mem_cycle;
    logic      ext_ok;     // External chip may be enabled
    logic      sel_rom;
    logic      sel_cart;
    logic      sel_ram;

    //////////////////////////////
    // Window select
    //////////////////////////////
    always_comb begin
        case (a[15:14])
            2'd0:    bank = bank0;
            2'd1:    bank = bank1;
            2'd2:    bank = bank2;
            default: bank = bank3;
        endcase
    end

    //////////////////////////////
    // Memory decode
    //////////////////////////////
    always_comb begin
        mem_cycle = !mreq_n;

        // Overlay windows in the top 4 KB of the 16 KB window
        sel_vram    = mem_cycle && bank.overlay && a[13:11] == `EBUS_VRAM_WIN;
        sel_sysram  = mem_cycle && bank.overlay && a[13:11] == `EBUS_SYSRAM_WIN;
        sel_bootrom = mem_cycle && bank.page == `EBUS_BOOT_PAGE
                      && !sel_vram && !sel_sysram;

        // Internal targets and write protection keep the bus chips off
        ext_ok = mem_cycle && !sel_io_any && !sel_vram && !sel_bootrom && !sel_sysram
                 && (wr_n || !bank.ro);

        sel_rom  = ext_ok && bank.page <= `EBUS_ROM_PAGE_LAST;
        sel_cart = ext_ok && bank.page >= `EBUS_CART_PAGE_FIRST
                   && bank.page <= `EBUS_CART_PAGE_LAST;
        sel_ram  = ext_ok && bank.page >= `EBUS_RAM_PAGE_FIRST;

        ba = sel_sysram ? 5'd0 : bank.page[4:0];  // Sysram lives in RAM page 0

        rom_ce_n  = !sel_rom;
        ram_ce_n  = !(sel_ram || sel_sysram);  // Sysram ignores RO
        cart_ce_n = !sel_cart;

        // Only one chip may drive the data bus
        a_ce_onehot: assert ($onehot0({!rom_ce_n, !ram_ce_n, !cart_ce_n}))
            else $error("bank_map: more than one chip enable low");
    end

endmodule

// ==== rtl/io_regs.sv ====
`timescale 1ns/1ps
`include "ebus_settings.svh"

module io_regs import ebus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] a,
    input  logic        iorq_n,
    input  logic        bus_write,
    input  logic [7:0]  wrdata,
    input  logic        sel_vram,
    input  logic        sel_bootrom,
    input  logic [7:0]  vram_rddata,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        vblank,
    input  logic [63:0] keys,
    output bank_reg_t   bank0,
    output bank_reg_t   bank1,
    output bank_reg_t   bank2,
    output bank_reg_t   bank3,
    output logic        sel_io_any,
    output logic        sel_internal,
    output logic [7:0]  rddata,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        cpm_remap,
    output logic [7:0]  scramble
);

    logic       io_cycle;
    logic       sel_io_bank0;
    logic       sel_io_bank1;
    logic       sel_io_bank2;
    logic       sel_io_bank3;
    logic       sel_io_cassette;
    logic       sel_io_vsync_cpm;
    logic       sel_io_printer;
    logic       sel_io_keyb_scramble;
    logic [7:0] keyb_data;

    //////////////////////////////
    // Port decode
    //////////////////////////////
    assign io_cycle             = !iorq_n;
    assign sel_io_bank0         = io_cycle && a[7:0] == `EBUS_IO_BANK0;
    assign sel_io_bank1         = io_cycle && a[7:0] == `EBUS_IO_BANK1;
    assign sel_io_bank2         = io_cycle && a[7:0] == `EBUS_IO_BANK2;
    assign sel_io_bank3         = io_cycle && a[7:0] == `EBUS_IO_BANK3;
    assign sel_io_cassette      = io_cycle && a[7:0] == `EBUS_IO_CASSETTE;
    assign sel_io_vsync_cpm     = io_cycle && a[7:0] == `EBUS_IO_VSYNC_CPM;
    assign sel_io_printer       = io_cycle && a[7:0] == `EBUS_IO_PRINTER;
    assign sel_io_keyb_scramble = io_cycle && a[7:0] == `EBUS_IO_KEYB_SCRAMBLE;

    assign sel_io_any = sel_io_bank0 || sel_io_bank1 || sel_io_bank2 || sel_io_bank3
                        || sel_io_cassette || sel_io_vsync_cpm || sel_io_printer
                        || sel_io_keyb_scramble;

    assign sel_internal = sel_io_any || sel_vram || sel_bootrom;  // FPGA drives d

    // Keyboard matrix, a row takes part when its address line is low
    always_comb begin
        keyb_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!a[8 + row]) begin
                keyb_data = keyb_data & keys[8*row +: 8];
            end
        end
    end

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank0        <= `EBUS_BANK0_RESET;
            bank1        <= `EBUS_BANK1_RESET;
            bank2        <= `EBUS_BANK2_RESET;
            bank3        <= `EBUS_BANK3_RESET;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
            cpm_remap    <= 1'b0;
            scramble     <= 8'h00;
        end else if (bus_write) begin
            if (sel_io_bank0)         bank0        <= wrdata;
            if (sel_io_bank1)         bank1        <= wrdata;
            if (sel_io_bank2)         bank2        <= wrdata;
            if (sel_io_bank3)         bank3        <= wrdata;
            if (sel_io_cassette)      cassette_out <= wrdata[0];
            if (sel_io_vsync_cpm)     cpm_remap    <= wrdata[0];
            if (sel_io_printer)       printer_out  <= wrdata[0];
            if (sel_io_keyb_scramble) scramble     <= wrdata;  // Cartridge XOR key
        end
    end

    // Read data, boot ROM area and unmapped space read as 0
    always_comb begin
        rddata = 8'h00;
        if (sel_vram)             rddata = vram_rddata;
        if (sel_io_bank0)         rddata = bank0;
        if (sel_io_bank1)         rddata = bank1;
        if (sel_io_bank2)         rddata = bank2;
        if (sel_io_bank3)         rddata = bank3;
        if (sel_io_cassette)      rddata = {7'b0, cassette_in};
        if (sel_io_vsync_cpm)     rddata = {7'b0, !vblank};
        if (sel_io_printer)       rddata = {7'b0, printer_in};
        if (sel_io_keyb_scramble) rddata = keyb_data;
    end

    a_io_onehot: assert property (
        @(posedge sysclk) disable iff (reset)
        $onehot0({sel_io_bank0, sel_io_bank1, sel_io_bank2, sel_io_bank3,
                  sel_io_cassette, sel_io_vsync_cpm, sel_io_printer,
                  sel_io_keyb_scramble})
    ) else $error("io_regs: I/O decode not one-hot");

endmodule

// ==== rtl/vram.sv ====
`timescale 1ns/1ps
`include "ebus_settings.svh"

module vram (
    input  logic        sysclk,
    input  logic [10:0] addr,
    input  logic [7:0]  wrdata,
    input  logic        wren,
    output logic [7:0]  rddata
);

    //////////////////////////////
    // Storage
    //////////////////////////////
    logic [7:0] mem [0:`EBUS_VRAM_BYTES-1];  // Character cells

    always_ff @(posedge sysclk) begin
        if (wren) begin
            mem[addr] <= wrdata;
        end
    end

    // Asynchronous read, data valid while rd_n is low
    assign rddata = mem[addr];

endmodule

// ==== rtl/ebus_top.sv ====
`timescale 1ns/1ps

module ebus_top import ebus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] a,
    input  logic [7:0]  d_in,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        vblank,
    input  logic [63:0] keys,
    output logic [7:0]  d_out,
    output logic        d_oe,
    output logic [4:0]  ba,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic        cart_ce_n,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        cpm_remap,
    output logic [7:0]  scramble
);

    logic       bus_write;
    logic [7:0] wrdata;
    bank_reg_t  bank0;
    bank_reg_t  bank1;
    bank_reg_t  bank2;
    bank_reg_t  bank3;
    logic       sel_vram;
    logic       sel_bootrom;
    logic       sel_io_any;
    logic       sel_internal;
    logic       vram_wren;
    logic [7:0] vram_rddata;

    //////////////////////////////
    // Bus front end
    //////////////////////////////
    strobe_sync u_strobe_sync (
        .sysclk    (sysclk),
        .reset     (reset),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .d_in      (d_in),
        .bus_read  (),          // No read side effects in this subsystem
        .bus_write (bus_write),
        .wrdata    (wrdata)
    );

    bank_map u_bank_map (
        .a           (a),
        .mreq_n      (mreq_n),
        .wr_n        (wr_n),
        .bank0       (bank0),
        .bank1       (bank1),
        .bank2       (bank2),
        .bank3       (bank3),
        .sel_io_any  (sel_io_any),
        .sel_vram    (sel_vram),
        .sel_sysram  (),
        .sel_bootrom (sel_bootrom),
        .ba          (ba),
        .rom_ce_n    (rom_ce_n),
        .ram_ce_n    (ram_ce_n),
        .cart_ce_n   (cart_ce_n)
    );

    io_regs u_io_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .a            (a),
        .iorq_n       (iorq_n),
        .bus_write    (bus_write),
        .wrdata       (wrdata),
        .sel_vram     (sel_vram),
        .sel_bootrom  (sel_bootrom),
        .vram_rddata  (vram_rddata),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .vblank       (vblank),
        .keys         (keys),
        .bank0        (bank0),
        .bank1        (bank1),
        .bank2        (bank2),
        .bank3        (bank3),
        .sel_io_any   (sel_io_any),
        .sel_internal (sel_internal),
        .rddata       (d_out),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .cpm_remap    (cpm_remap),
        .scramble     (scramble)
    );

    //////////////////////////////
    // Video RAM window
    //////////////////////////////
    assign vram_wren = bus_write && sel_vram;

    vram u_vram (
        .sysclk (sysclk),
        .addr   (a[10:0]),
        .wrdata (wrdata),
        .wren   (vram_wren),
        .rddata (vram_rddata)
    );

    assign d_oe = !rd_n && sel_internal;  // Drive d only for our own targets

endmodule

// ==== tests/tb_ebus.sv ====
`timescale 1ns/1ps

module tb_ebus;

    logic        sysclk;
    logic        reset;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic        cassette_in;
    logic        printer_in;
    logic        vblank;
    logic [63:0] keys;
    logic [7:0]  d_out;
    logic        d_oe;
    logic [4:0]  ba;
    logic        rom_ce_n;
    logic        ram_ce_n;
    logic        cart_ce_n;
    logic        cassette_out;
    logic        printer_out;
    logic        cpm_remap;
    logic [7:0]  scramble;

    ebus_top uut (.*);

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    localparam logic [1:0] op_io_wr  = 2'd0;
    localparam logic [1:0] op_io_rd  = 2'd1;
    localparam logic [1:0] op_mem_wr = 2'd2;
    localparam logic [1:0] op_mem_rd = 2'd3;

    localparam int num_entries   = 31;
    localparam int num_kb        = 8;
    localparam int num_pin_reads = 3;
    localparam int cycle_limit   = (num_entries + num_kb + num_pin_reads) * 12 + 100;

    // {op, address, write data, expected d_out or ba, {rom, ram, cart} enables}
    localparam logic [36:0] stim_table [num_entries] = '{
        {op_io_rd,  16'h00F0, 8'h00, 8'hDF, 3'b111},  // Reset values
        {op_io_rd,  16'h00F1, 8'h00, 8'h21, 3'b111},
        {op_io_rd,  16'h00F2, 8'h00, 8'h22, 3'b111},
        {op_io_rd,  16'h00F3, 8'h00, 8'h13, 3'b111},
        {op_mem_rd, 16'h0000, 8'h00, 8'h00, 3'b111},  // Boot page reads 0
        {op_mem_rd, 16'h4000, 8'h00, 8'h01, 3'b101},  // Page 33, RAM
        {op_mem_rd, 16'hC000, 8'h00, 8'h13, 3'b110},  // Page 19, cartridge
        {op_mem_rd, 16'h3800, 8'h00, 8'h00, 3'b101},  // Overlay sysram
        {op_io_wr,  16'h00F2, 8'h05, 8'h00, 3'b111},
        {op_io_rd,  16'h00F2, 8'h00, 8'h05, 3'b111},
        {op_mem_rd, 16'h8123, 8'h00, 8'h05, 3'b011},  // Page 5, ROM
        {op_io_wr,  16'h00F1, 8'hA5, 8'h00, 3'b111},  // RO, page 37
        {op_io_rd,  16'h00F1, 8'h00, 8'hA5, 3'b111},
        {op_mem_wr, 16'h4000, 8'h11, 8'h00, 3'b111},  // Blocked write
        {op_mem_rd, 16'h4000, 8'h00, 8'h05, 3'b101},
        {op_io_wr,  16'h00F3, 8'h11, 8'h00, 3'b111},
        {op_mem_rd, 16'hC010, 8'h00, 8'h11, 3'b110},
        {op_io_wr,  16'h00F2, 8'h60, 8'h00, 3'b111},  // Overlay, page 32
        {op_mem_wr, 16'hB000, 8'h3C, 8'h00, 3'b111},
        {op_mem_wr, 16'hB7FF, 8'hC5, 8'h00, 3'b111},
        {op_mem_wr, 16'h3001, 8'h5A, 8'h00, 3'b111},
        {op_mem_rd, 16'hB000, 8'h00, 8'h3C, 3'b111},
        {op_mem_rd, 16'hB7FF, 8'h00, 8'hC5, 3'b111},
        {op_mem_rd, 16'h3001, 8'h00, 8'h5A, 3'b111},
        {op_mem_rd, 16'hB800, 8'h00, 8'h00, 3'b101},
        {op_io_rd,  16'h00FC, 8'h00, 8'h01, 3'b111},  // cassette_in high
        {op_io_rd,  16'h00FE, 8'h00, 8'h00, 3'b111},
        {op_io_rd,  16'h00FD, 8'h00, 8'h00, 3'b111},  // vblank high
        {op_io_wr,  16'h00FC, 8'h01, 8'h00, 3'b111},
        {op_io_wr,  16'h00FE, 8'h01, 8'h00, 3'b111},
        {op_io_wr,  16'h00FD, 8'h01, 8'h00, 3'b111}
    };

    localparam logic [7:0] kb_rows [num_kb] = '{
        8'hFE, 8'hFD, 8'h7F, 8'h00, 8'hFF, 8'hAA, 8'h0F, 8'hF0
    };

    integer      seed = 32'h8ee9;
    int          cycle_count = 0;
    logic [36:0] entry;
    logic [1:0]  op;
    logic [7:0]  exp_val;
    logic [2:0]  exp_ce;
    logic        exp_oe;
    logic [7:0]  got_d;
    logic        got_oe;
    logic [2:0]  got_ce;
    logic [4:0]  got_ba;

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, bus sequence did not finish", cycle_count);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Strobe low for 5 cycles, outputs sampled mid-cycle
    task automatic bus_cycle(input logic is_io, input logic is_wr,
                             input logic [15:0] addr, input logic [7:0] data);
        @(posedge sysclk);
        a      <= addr;
        d_in   <= data;
        iorq_n <= !is_io;
        mreq_n <= is_io;
        wr_n   <= !is_wr;
        rd_n   <= is_wr;
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        got_d  = d_out;
        got_oe = d_oe;
        got_ce = {rom_ce_n, ram_ce_n, cart_ce_n};
        got_ba = ba;
        repeat (2) @(posedge sysclk);
        {iorq_n, mreq_n, rd_n, wr_n} <= 4'hF;
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        bus_cycle(1'b1, 1'b1, addr, data);
    endtask

    task automatic io_read(input logic [15:0] addr);
        bus_cycle(1'b1, 1'b0, addr, 8'h00);
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        bus_cycle(1'b0, 1'b1, addr, data);
    endtask

    task automatic mem_read(input logic [15:0] addr);
        bus_cycle(1'b0, 1'b0, addr, 8'h00);
    endtask

    // Rows with a low address bit are ANDed together
    function automatic logic [7:0] key_scan(input logic [7:0] hi, input logic [63:0] k);
        logic [7:0] res;
        res = 8'hFF;
        for (int r = 0; r < 8; r++) begin
            if (!hi[r]) res = res & k[8*r +: 8];
        end
        return res;
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        reset = 1'b1;
        {a, d_in} = '0;
        {rd_n, wr_n, mreq_n, iorq_n} = 4'hF;  // Bus idle
        cassette_in = 1'b1;
        printer_in  = 1'b0;
        vblank      = 1'b1;
        keys        = {$random(seed), $random(seed)};
        repeat (5) @(posedge sysclk);
        reset <= 1'b0;
        @(negedge sysclk);
        compare_value("chip enables", {rom_ce_n, ram_ce_n, cart_ce_n}, 3'b111);
        compare_value("d_oe", d_oe, 1'b0);
        compare_value("outputs", {cassette_out, printer_out, cpm_remap, scramble}, 11'h0);

        for (int i = 0; i < num_entries; i++) begin
            entry   = stim_table[i];
            op      = entry[36:35];
            exp_val = entry[10:3];
            exp_ce  = entry[2:0];
            case (op)
                op_io_wr:  io_write(entry[34:19], entry[18:11]);
                op_io_rd:  io_read(entry[34:19]);
                op_mem_wr: mem_write(entry[34:19], entry[18:11]);
                default:   mem_read(entry[34:19]);
            endcase
            exp_oe = op[0] && (!op[1] || exp_ce == 3'b111);
            compare_value("chip enables", got_ce, exp_ce);
            compare_value("d_oe", got_oe, exp_oe);
            if (exp_oe) begin
                compare_value("d_out", got_d, exp_val);
            end else if (exp_ce != 3'b111) begin
                compare_value("ba", got_ba, exp_val[4:0]);
            end
        end

        io_write(16'h00FF, 8'hA7);  // Scramble key
        @(negedge sysclk);
        compare_value("cassette_out", cassette_out, 1'b1);
        compare_value("printer_out", printer_out, 1'b1);
        compare_value("cpm_remap", cpm_remap, 1'b1);
        compare_value("scramble", scramble, 8'hA7);

        // Input pins flipped from their first state
        @(posedge sysclk);
        cassette_in <= 1'b0;
        printer_in  <= 1'b1;
        vblank      <= 1'b0;
        io_read(16'h00FC);
        compare_value("d_out", got_d, 8'h00);
        io_read(16'h00FE);
        compare_value("d_out", got_d, 8'h01);
        io_read(16'h00FD);
        compare_value("d_out", got_d, 8'h01);  // vblank low

        for (int i = 0; i < num_kb; i++) begin
            io_read({kb_rows[i], 8'hFF});
            compare_value("d_oe", got_oe, 1'b1);
            compare_value("d_out", got_d, key_scan(kb_rows[i], keys));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
rtl/ebus_pkg.sv
rtl/strobe_sync.sv
rtl/bank_map.sv
rtl/io_regs.sv
rtl/vram.sv
rtl/ebus_top.sv
tests/tb_ebus.sv

// ==== Makefile ====
# Verilator build and run for the expansion-bus front end

VERILATOR ?= verilator
TOP       ?= tb_ebus
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
